// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=ioTopSim

rm -rf obj_dir

if ! verilator --binary --timing -Wno-fatal --top-module ioTopTb -f sources.f -o "$BIN"; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/"$BIN" > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -q "Test passed" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: sources.f
src/mmioPkg.sv
src/regBusIf.sv
src/busSlaveFsm.sv
src/ioTimer.sv
src/switchDebouncer.sv
src/keyCapture.sv
src/displayRegs.sv
src/ioTop.sv
tests/ioTopTb.sv

// File: src/busSlaveFsm.sv
`timescale 1ns/1ps

module busSlaveFsm import mmioPkg::*; (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [AddrWidth-1:0] adr,
	input logic [DataWidth-1:0] datIn,
	output logic [DataWidth-1:0] datOut,
	output logic ack,
	regBusIf.controller bus
);

	busState_t state;
	logic [DataWidth-1:0] readMux;

	// full compare, anything unmapped falls to RegNone
	function automatic regSel_t decodeAddr(input logic [AddrWidth-1:0] a);
		case (a)
			HexAddr: return RegHex;
			LedAddr: return RegLed;
			KeyAddr: return RegKey;
			KeyCtlAddr: return RegKeyCtl;
			SwAddr: return RegSw;
			SwCtlAddr: return RegSwCtl;
			TimCntAddr: return RegTimCnt;
			TimLimAddr: return RegTimLim;
			TimCtlAddr: return RegTimCtl;
			default: return RegNone;
		endcase
	endfunction

	// pick the field of the block that owns sel
	always_comb begin
		case (bus.sel)
			RegHex, RegLed: readMux = bus.displayData;
			RegKey, RegKeyCtl: readMux = bus.keyData;
			RegSw, RegSwCtl: readMux = bus.switchData;
			RegTimCnt, RegTimLim, RegTimCtl: readMux = bus.timerData;
			default: readMux = '0;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= Idle;
			bus.sel <= RegNone;
			bus.wrData <= '0;
			bus.wr <= 1'b0;
			bus.rd <= 1'b0;
			ack <= 1'b0;
			datOut <= '0;
		end else begin
			case (state)
				Idle: begin
					if (cyc && stb) begin
						state <= Access;
						bus.sel <= decodeAddr(adr);
						bus.wrData <= datIn;
						bus.wr <= we;
						bus.rd <= !we;
					end
				end
				Access: begin
					// strobes last exactly this one cycle
					state <= Ack;
					bus.wr <= 1'b0;
					bus.rd <= 1'b0;
					ack <= 1'b1;
					datOut <= bus.rd ? readMux : '0;
				end
				default: begin
					state <= Idle;
					ack <= 1'b0;
					datOut <= '0;
				end
			endcase
		end
	end

endmodule

// File: src/displayRegs.sv
`timescale 1ns/1ps

module displayRegs import mmioPkg::*; (
	input logic clk,
	input logic reset,
	regBusIf.display bus,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [LedWidth-1:0] ledr
);

	logic [HexWidth-1:0] hexReg;
	logic [LedWidth-1:0] ledReg;
	logic [HexDigits-1:0][6:0] segs;

	// active low, bit 6 is segment g
	function automatic logic [6:0] sevenSeg(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'hA: return 7'b0001000;
			4'hB: return 7'b0000011;
			4'hC: return 7'b1000110;
			4'hD: return 7'b0100001;
			4'hE: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hexReg <= HexResetValue;
			ledReg <= '0;
		end else if (bus.wr) begin
			if (bus.sel == RegHex)
				hexReg <= bus.wrData[HexWidth-1:0];
			if (bus.sel == RegLed)
				ledReg <= bus.wrData[LedWidth-1:0];
		end
	end

	// digit 0 is the low nibble
	always_comb begin
		for (int i = 0; i < HexDigits; i++)
			segs[i] = sevenSeg(hexReg[4*i +: 4]);
	end

	assign hex0 = segs[0];
	assign hex1 = segs[1];
	assign hex2 = segs[2];
	assign hex3 = segs[3];
	assign hex4 = segs[4];
	assign hex5 = segs[5];
	assign ledr = ledReg;

	always_comb begin
		case (bus.sel)
			RegHex: bus.displayData = DataWidth'(hexReg);
			RegLed: bus.displayData = DataWidth'(ledReg);
			default: bus.displayData = '0;
		endcase
	end

endmodule

// File: src/ioTimer.sv
`timescale 1ns/1ps

module ioTimer import mmioPkg::*; (
	input logic clk,
	input logic reset,
	regBusIf.timer bus
);

	logic [TickWidth-1:0] prescale;
	logic tick;
	logic [DataWidth-1:0] count;
	logic [DataWidth-1:0] limit;
	logic [FlagWidth-1:0] flags;
	logic limHit;
	logic cntWrite;
	logic limWrite;
	logic ctlWrite;

	assign tick = (prescale == TickWidth'(TickCycles - 1));

	// compare only counts on a tick, and a zero limit never wraps
	assign limHit = tick && (limit != '0) && (count == limit - 1'b1);

	assign cntWrite = bus.wr && (bus.sel == RegTimCnt);
	assign limWrite = bus.wr && (bus.sel == RegTimLim);
	assign ctlWrite = bus.wr && (bus.sel == RegTimCtl);

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			prescale <= '0;
		else
			prescale <= tick ? '0 : prescale + 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			limit <= '0;
			flags <= '0;
		end else begin
			// bus write beats the tick
			if (cntWrite)
				count <= bus.wrData;
			else if (limHit)
				count <= '0;
			else if (tick)
				count <= count + 1'b1;

			if (limWrite)
				limit <= bus.wrData;

			if (ctlWrite) begin
				flags <= flags & bus.wrData[FlagWidth-1:0];
			end else if (limHit) begin
				flags[ReadyBit] <= 1'b1;
				if (flags[ReadyBit])
					flags[OverrunBit] <= 1'b1;
			end
		end
	end

	always_comb begin
		case (bus.sel)
			RegTimCnt: bus.timerData = count;
			RegTimLim: bus.timerData = limit;
			RegTimCtl: bus.timerData = DataWidth'(flags);
			default: bus.timerData = '0;
		endcase
	end

endmodule

// File: src/ioTop.sv
`timescale 1ns/1ps

module ioTop import mmioPkg::*; (
	input logic clk,
	input logic reset,
	// wishbone classic slave
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [AddrWidth-1:0] adr,
	input logic [DataWidth-1:0] datIn,
	output logic [DataWidth-1:0] datOut,
	output logic ack,
	// board devices
	input logic [KeyWidth-1:0] key,
	input logic [SwWidth-1:0] sw,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [LedWidth-1:0] ledr
);

	regBusIf bus0 ();

	busSlaveFsm busSlave0 (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack),
		.bus(bus0.controller)
	);

	ioTimer timer0 (.clk(clk), .reset(reset), .bus(bus0.timer));

	switchDebouncer switch0 (.clk(clk), .reset(reset), .sw(sw), .bus(bus0.switch));

	keyCapture key0 (.clk(clk), .reset(reset), .key(key), .bus(bus0.key));

	displayRegs display0 (
		.clk(clk),
		.reset(reset),
		.bus(bus0.display),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5),
		.ledr(ledr)
	);

endmodule

// File: src/keyCapture.sv
`timescale 1ns/1ps

module keyCapture import mmioPkg::*; (
	input logic clk,
	input logic reset,
	input logic [KeyWidth-1:0] key,
	regBusIf.key bus
);

	logic [KeyWidth-1:0] keySync1;
	logic [KeyWidth-1:0] keySync2;
	logic [KeyWidth-1:0] keyData;
	logic [FlagWidth-1:0] flags;
	logic [FlagWidth-1:0] flagsNext;
	logic keyChange;

	// pins are active low, the data register is not
	assign keyChange = (~keySync2 != keyData);

	always_comb begin
		flagsNext = flags;
		if (bus.wr && bus.sel == RegKeyCtl)
			flagsNext = flagsNext & bus.wrData[FlagWidth-1:0];
		if (bus.rd && bus.sel == RegKey)
			flagsNext[ReadyBit] = 1'b0;
		// a change in the same cycle keeps ready set
		if (keyChange) begin
			if (flags[ReadyBit])
				flagsNext[OverrunBit] = 1'b1;
			flagsNext[ReadyBit] = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			keySync1 <= '1;
			keySync2 <= '1;
			keyData <= '0;
			flags <= '0;
		end else begin
			keySync1 <= key;
			keySync2 <= keySync1;
			keyData <= ~keySync2;
			flags <= flagsNext;
		end
	end

	always_comb begin
		case (bus.sel)
			RegKey: bus.keyData = DataWidth'(keyData);
			RegKeyCtl: bus.keyData = DataWidth'(flags);
			default: bus.keyData = '0;
		endcase
	end

endmodule

// File: src/mmioPkg.sv
package mmioPkg;

	// bus geometry
	localparam int DataWidth = 32;
	localparam int AddrWidth = 12;

	// register map, byte offsets
	localparam logic [AddrWidth-1:0] HexAddr    = 12'h000;
	localparam logic [AddrWidth-1:0] LedAddr    = 12'h020;
	localparam logic [AddrWidth-1:0] KeyAddr    = 12'h080;
	localparam logic [AddrWidth-1:0] KeyCtlAddr = 12'h084;
	localparam logic [AddrWidth-1:0] SwAddr     = 12'h090;
	localparam logic [AddrWidth-1:0] SwCtlAddr  = 12'h094;
	localparam logic [AddrWidth-1:0] TimCntAddr = 12'h100;
	localparam logic [AddrWidth-1:0] TimLimAddr = 12'h104;
	localparam logic [AddrWidth-1:0] TimCtlAddr = 12'h108;

	// device widths
	localparam int HexDigits = 6;
	localparam int HexWidth = 24;
	localparam logic [HexWidth-1:0] HexResetValue = 24'hFEDEAD;
	localparam int LedWidth = 10;
	localparam int KeyWidth = 4;
	localparam int SwWidth = 10;

	// timing, kept short for simulation
	localparam int TickCycles = 16;
	localparam int TickWidth = 4;
	localparam int DebounceCycles = 64;
	localparam int DebounceWidth = 7;

	// layout of the KeyCtl, SwCtl and TimCtl registers
	localparam int FlagWidth = 2;
	localparam int ReadyBit = 0;
	localparam int OverrunBit = 1;

	typedef enum logic [1:0] {
		Idle,
		Access,
		Ack
	} busState_t;

	// one opcode per register
	typedef enum logic [3:0] {
		RegNone,
		RegHex,
		RegLed,
		RegKey,
		RegKeyCtl,
		RegSw,
		RegSwCtl,
		RegTimCnt,
		RegTimLim,
		RegTimCtl
	} regSel_t;

endpackage

// File: src/regBusIf.sv
`timescale 1ns/1ps

interface regBusIf import mmioPkg::*; ();

	// driven by the bus slave
	regSel_t sel;
	logic [DataWidth-1:0] wrData;
	logic wr;
	logic rd;

	// read fields, one per peripheral
	logic [DataWidth-1:0] timerData;
	logic [DataWidth-1:0] keyData;
	logic [DataWidth-1:0] switchData;
	logic [DataWidth-1:0] displayData;

	modport controller (
		output sel, wrData, wr, rd,
		input timerData, keyData, switchData, displayData
	);

	modport timer (input sel, wrData, wr, output timerData);
	modport key (input sel, wrData, wr, rd, output keyData);
	modport switch (input sel, rd, output switchData);
	modport display (input sel, wrData, wr, output displayData);

endinterface

// File: src/switchDebouncer.sv
`timescale 1ns/1ps

module switchDebouncer import mmioPkg::*; (
	input logic clk,
	input logic reset,
	input logic [SwWidth-1:0] sw,
	regBusIf.switch bus
);

	logic [SwWidth-1:0] swSync1;
	logic [SwWidth-1:0] swSync2;
	logic [SwWidth-1:0] swData;
	logic [DebounceWidth-1:0] stableCnt;
	logic [FlagWidth-1:0] flags;
	logic accept;
	logic dataRead;

	// new value held long enough
	assign accept = (swSync2 != swData) && (stableCnt == DebounceWidth'(DebounceCycles));
	assign dataRead = bus.rd && (bus.sel == RegSw);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			swSync1 <= '0;
			swSync2 <= '0;
		end else begin
			swSync1 <= sw;
			swSync2 <= swSync1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stableCnt <= '0;
			swData <= '0;
			flags <= '0;
		end else begin
			// any glitch back to the old value restarts the count
			if (swSync2 == swData || accept)
				stableCnt <= '0;
			else
				stableCnt <= stableCnt + 1'b1;

			if (accept) begin
				swData <= swSync2;
				flags[ReadyBit] <= 1'b1;
				if (flags[ReadyBit])
					flags[OverrunBit] <= 1'b1;
			end else if (dataRead) begin
				flags[ReadyBit] <= 1'b0;
			end
		end
	end

	// read only, writes from the bus are dropped
	always_comb begin
		case (bus.sel)
			RegSw: bus.switchData = DataWidth'(swData);
			RegSwCtl: bus.switchData = DataWidth'(flags);
			default: bus.switchData = '0;
		endcase
	end

endmodule

// File: tests/ioTopTb.sv
`timescale 1ns/1ps

module ioTopTb import mmioPkg::*; ();

	localparam int StimDelay = 1;
	localparam int AckTimeout = 8;
	localparam int MaxSteps = 128;

	typedef enum logic [3:0] {
		StepWrite,
		StepRead,
		StepBelow,
		StepPoll,
		StepSync,
		StepKey,
		StepSw,
		StepWait,
		StepPins
	} stepKind_t;

	typedef struct {
		stepKind_t kind;
		logic [AddrWidth-1:0] addr;
		logic [DataWidth-1:0] value;
		logic [DataWidth-1:0] expected;
		logic [DataWidth-1:0] mask;
	} step_t;

	logic clk = 1'b0;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [AddrWidth-1:0] adr;
	logic [DataWidth-1:0] datIn;
	logic [DataWidth-1:0] datOut;
	logic ack;
	logic [KeyWidth-1:0] key;
	logic [SwWidth-1:0] sw;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;
	logic [LedWidth-1:0] ledr;

	step_t steps [MaxSteps];
	int numSteps = 0;
	int errors = 0;
	int timeouts = 0;
	int seed = 32'h75c4;

	// what the display block should hold
	logic [HexWidth-1:0] hexModel = HexResetValue;
	logic [LedWidth-1:0] ledModel = '0;

	ioTop dut0 (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack),
		.key(key),
		.sw(sw),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5),
		.ledr(ledr)
	);

	always #4 clk = ~clk;

	// active-low segments, g in bit 6
	function automatic logic [6:0] segPattern(input logic [3:0] digit);
		case (digit)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'hA: return 7'h08;
			4'hB: return 7'h03;
			4'hC: return 7'h46;
			4'hD: return 7'h21;
			4'hE: return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	function automatic void addStep(input stepKind_t kind, input logic [AddrWidth-1:0] addr,
			input logic [DataWidth-1:0] value, input logic [DataWidth-1:0] expected,
			input logic [DataWidth-1:0] mask);
		steps[numSteps].kind = kind;
		steps[numSteps].addr = addr;
		steps[numSteps].value = value;
		steps[numSteps].expected = expected;
		steps[numSteps].mask = mask;
		numSteps++;
	endfunction

	// one wishbone classic cycle, entered and left 1 ns after a rising edge
	task automatic busTransfer(input logic write, input logic [AddrWidth-1:0] addr,
			input logic [DataWidth-1:0] wdata, output logic [DataWidth-1:0] rdata);
		int waited;
		logic gotAck;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		datIn = wdata;
		waited = 0;
		gotAck = 1'b0;
		while (!gotAck && waited < AckTimeout) begin
			@(posedge clk);
			#StimDelay;
			waited++;
			gotAck = ack;
		end
		rdata = datOut;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		if (!gotAck) begin
			$display("Timeout: no ack from the bus slave for address 0x%03h", addr);
			timeouts++;
		end else begin
			if (waited != 2) begin
				$display("ERROR at %0t: ack came after %0d edges, expected 2", $time, waited);
				errors++;
			end
			@(posedge clk);
			#StimDelay;
			if (ack) begin
				$display("ERROR at %0t: ack stayed high for more than one cycle", $time);
				errors++;
			end
		end
	endtask

	task automatic pollReg(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] mask,
			input logic [DataWidth-1:0] expected, input int limit);
		logic [DataWidth-1:0] rdata;
		int tries;
		logic done;
		tries = 0;
		done = 1'b0;
		while (!done && tries < limit) begin
			busTransfer(1'b0, addr, '0, rdata);
			tries++;
			done = ((rdata & mask) == expected);
		end
		if (!done) begin
			$display("Timeout: register 0x%03h never showed 0x%0h under mask 0x%0h",
				addr, expected, mask);
			timeouts++;
		end
	endtask

	// returns just after the register value moves, e.g. right after a timer tick
	task automatic waitForChange(input logic [AddrWidth-1:0] addr, input int limit);
		logic [DataWidth-1:0] first;
		logic [DataWidth-1:0] rdata;
		int tries;
		busTransfer(1'b0, addr, '0, first);
		rdata = first;
		tries = 0;
		while (rdata == first && tries < limit) begin
			busTransfer(1'b0, addr, '0, rdata);
			tries++;
		end
		if (rdata == first) begin
			$display("Timeout: register 0x%03h did not change", addr);
			timeouts++;
		end
	endtask

	task automatic checkPins();
		logic [6:0] pins [HexDigits];
		logic [6:0] want;
		pins[0] = hex0;
		pins[1] = hex1;
		pins[2] = hex2;
		pins[3] = hex3;
		pins[4] = hex4;
		pins[5] = hex5;
		for (int d = 0; d < HexDigits; d++) begin
			want = segPattern(hexModel[4*d +: 4]);
			if (pins[d] !== want) begin
				$display("ERROR at %0t: hex%0d is 0x%02h, expected 0x%02h", $time, d, pins[d], want);
				errors++;
			end
		end
		if (ledr !== ledModel) begin
			$display("ERROR at %0t: ledr is 0x%03h, expected 0x%03h", $time, ledr, ledModel);
			errors++;
		end
	endtask

	task automatic runStep(input step_t s);
		logic [DataWidth-1:0] rdata;
		case (s.kind)
			StepWrite: begin
				busTransfer(1'b1, s.addr, s.value, rdata);
				if (s.addr == HexAddr)
					hexModel = s.value[HexWidth-1:0];
				if (s.addr == LedAddr)
					ledModel = s.value[LedWidth-1:0];
			end
			StepRead: begin
				busTransfer(1'b0, s.addr, '0, rdata);
				if (rdata !== s.expected) begin
					$display("ERROR at %0t: read 0x%03h gave 0x%08h, expected 0x%08h",
						$time, s.addr, rdata, s.expected);
					errors++;
				end
			end
			StepBelow: begin
				busTransfer(1'b0, s.addr, '0, rdata);
				if (rdata >= s.expected) begin
					$display("ERROR at %0t: read 0x%03h gave 0x%08h, expected below 0x%08h",
						$time, s.addr, rdata, s.expected);
					errors++;
				end
			end
			StepPoll: pollReg(s.addr, s.mask, s.expected, s.value);
			StepSync: waitForChange(s.addr, s.value);
			StepKey: key = s.value[KeyWidth-1:0];
			StepSw: sw = s.value[SwWidth-1:0];
			StepWait: begin
				for (int n = 0; n < s.value; n++) begin
					@(posedge clk);
					#StimDelay;
				end
			end
			default: checkPins();
		endcase
	endtask

	task automatic buildTable();
		logic [DataWidth-1:0] r;
		// reset values and decode
		addStep(StepRead, HexAddr, 0, 32'(HexResetValue), '1);
		addStep(StepPins, 0, 0, 0, 0);
		addStep(StepRead, LedAddr, 0, 0, '1);
		addStep(StepRead, KeyCtlAddr, 0, 0, '1);
		addStep(StepRead, SwCtlAddr, 0, 0, '1);
		addStep(StepRead, TimCtlAddr, 0, 0, '1);
		addStep(StepRead, TimLimAddr, 0, 0, '1);
		addStep(StepRead, 12'h200, 0, 0, '1);
		addStep(StepRead, 12'h024, 0, 0, '1);
		addStep(StepWrite, KeyAddr, 32'hF, 0, 0);
		addStep(StepRead, KeyAddr, 0, 0, '1);
		addStep(StepRead, KeyCtlAddr, 0, 0, '1);
		// display registers with random data
		for (int k = 0; k < 3; k++) begin
			r = $random(seed);
			addStep(StepWrite, HexAddr, r, 0, 0);
			addStep(StepRead, HexAddr, 0, 32'(r[HexWidth-1:0]), '1);
			r = $random(seed);
			addStep(StepWrite, LedAddr, r, 0, 0);
			addStep(StepRead, LedAddr, 0, 32'(r[LedWidth-1:0]), '1);
			addStep(StepPins, 0, 0, 0, 0);
		end
		// keys, pressed means low
		addStep(StepKey, 0, 32'hE, 0, 0);
		addStep(StepPoll, KeyCtlAddr, 10, 32'h1, 32'h1);
		addStep(StepRead, KeyCtlAddr, 0, 32'h1, '1);
		addStep(StepRead, KeyAddr, 0, 32'h1, '1);
		addStep(StepRead, KeyCtlAddr, 0, 32'h0, '1);
		addStep(StepKey, 0, 32'hC, 0, 0);
		addStep(StepWait, 0, 6, 0, 0);
		addStep(StepKey, 0, 32'hF, 0, 0);
		addStep(StepWait, 0, 6, 0, 0);
		addStep(StepRead, KeyCtlAddr, 0, 32'h3, '1);
		addStep(StepWrite, KeyCtlAddr, 0, 0, 0);
		addStep(StepRead, KeyCtlAddr, 0, 32'h0, '1);
		addStep(StepRead, KeyAddr, 0, 32'h0, '1);
		// switches, first a glitch shorter than the debounce time
		addStep(StepSw, 0, 32'h155, 0, 0);
		addStep(StepWait, 0, 20, 0, 0);
		addStep(StepSw, 0, 32'h000, 0, 0);
		addStep(StepWait, 0, DebounceCycles + 16, 0, 0);
		addStep(StepRead, SwAddr, 0, 32'h0, '1);
		addStep(StepRead, SwCtlAddr, 0, 32'h0, '1);
		addStep(StepSw, 0, 32'h2A5, 0, 0);
		addStep(StepPoll, SwCtlAddr, 40, 32'h1, 32'h1);
		addStep(StepRead, SwAddr, 0, 32'h2A5, '1);
		addStep(StepRead, SwCtlAddr, 0, 32'h0, '1);
		addStep(StepSw, 0, 32'h0F0, 0, 0);
		addStep(StepPoll, SwCtlAddr, 40, 32'h1, 32'h1);
		addStep(StepSw, 0, 32'h30F, 0, 0);
		addStep(StepWait, 0, DebounceCycles + 26, 0, 0);
		addStep(StepRead, SwCtlAddr, 0, 32'h3, '1);
		addStep(StepRead, SwAddr, 0, 32'h30F, '1);
		addStep(StepRead, SwCtlAddr, 0, 32'h2, '1);
		// timer wrapping every 3 ticks
		addStep(StepWrite, TimLimAddr, 32'd3, 0, 0);
		addStep(StepWrite, TimCntAddr, 32'd0, 0, 0);
		addStep(StepPoll, TimCtlAddr, 30, 32'h1, 32'h1);
		addStep(StepBelow, TimCntAddr, 0, 32'd3, '1);
		addStep(StepWait, 0, 4 * TickCycles, 0, 0);
		addStep(StepRead, TimCtlAddr, 0, 32'h3, '1);
		addStep(StepWrite, TimLimAddr, 32'd0, 0, 0);
		addStep(StepWrite, TimCtlAddr, 32'd0, 0, 0);
		addStep(StepRead, TimCtlAddr, 0, 32'h0, '1);
		addStep(StepSync, TimCntAddr, 10, 0, 0);
		addStep(StepWrite, TimCntAddr, 32'h5A, 0, 0);
		addStep(StepRead, TimCntAddr, 0, 32'h5A, '1);
	endtask

	initial begin
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		key = '1;
		sw = '0;
		buildTable();
		repeat (16) @(posedge clk);
		#StimDelay;
		reset = 1'b0;
		for (int i = 0; i < numSteps; i++)
			runStep(steps[i]);
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
